// File: hdl/acq_cfg_pkg.sv
package acq_cfg_pkg;

  // input beat layout
  localparam int LANES          = 8;
  localparam int LANE_W         = 16;
  localparam int SAMPLE_W       = 12;
  localparam int IN_W           = LANES * LANE_W;

  // output stream width
  localparam int OUT_W          = 64;
  localparam int WORDS_PER_BEAT = IN_W / OUT_W;

  // roughly 10 % of the 12-bit full scale
  localparam int THRESHOLD_LEVEL = 409;

  // frame shape in input beats
  localparam int PRE_BEATS      = 4;
  localparam int FRAME_BEATS    = 16;
  localparam int POST_BEATS     = FRAME_BEATS - PRE_BEATS - 1;
  localparam int FRAME_WORDS    = FRAME_BEATS * WORDS_PER_BEAT;

  localparam int RING_DEPTH     = 32;
  localparam int STAMP_W        = 32;

  // derived widths
  localparam int PTR_W          = $clog2(RING_DEPTH);
  localparam int LANE_IDX_W     = $clog2(LANES);
  localparam int HALF_W         = $clog2(WORDS_PER_BEAT);
  localparam int WCNT_W         = $clog2(FRAME_WORDS);

endpackage

// File: hdl/acq_types_pkg.sv
package acq_types_pkg;

  import acq_cfg_pkg::*;

  // one ADC beat, seen as lanes by the trigger and as raw bits by the ring
  typedef union packed {
    logic [LANES-1:0][LANE_W-1:0] lane;
    logic [IN_W-1:0]              raw;
  } adc_word_u;

  // captured at the trigger beat
  typedef struct packed {
    // beat index since reset
    logic [STAMP_W-1:0]    stamp;
    // lowest lane at or above threshold
    logic [LANE_IDX_W-1:0] lane;
    // ring slot holding the trigger beat
    logic [PTR_W-1:0]      beat_ptr;
  } trig_event_s;

  // one output stream beat
  typedef struct packed {
    logic [OUT_W-1:0] data;
    logic             user;
    logic             last;
  } axis_beat_s;

endpackage

// File: hdl/level_trigger.sv
`timescale 1ns/1ns

module level_trigger
  import acq_cfg_pkg::*, acq_types_pkg::*;
(
  input  logic             axis_aclk,
  input  logic             rst_n,
  input  adc_word_u        s_axis_tdata,
  input  logic             s_axis_tvalid,
  input  logic             busy,
  input  logic [PTR_W-1:0] wr_ptr,
  output logic             trig_fire,
  output trig_event_s      trig_evt
);

  logic [STAMP_W-1:0]    beat_cnt;
  logic [LANES-1:0]      over;
  logic [LANE_IDX_W-1:0] first_lane;
  logic                  prev_below;
  logic                  armed;
  logic [PTR_W-1:0]      refill_cnt;
  logic                  fire;

  // per-lane compare on the 12-bit sample, lowest hit wins
  always_comb
  begin
    first_lane = '0;
    for (int i = LANES - 1; i >= 0; i--)
    begin
      over[i] = s_axis_tdata.lane[i][SAMPLE_W-1:0] >= SAMPLE_W'(THRESHOLD_LEVEL);
      if (over[i])
        first_lane = LANE_IDX_W'(i);
    end
  end

  // rising crossing only
  assign fire = s_axis_tvalid && armed && prev_below && (|over);

  always_ff @(posedge axis_aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      beat_cnt   <= '0;
      prev_below <= 1'b0;
    end
    else if (s_axis_tvalid)
    begin
      beat_cnt   <= beat_cnt + 1'b1;
      prev_below <= ~|over;
    end
  end

  // re-arm after busy drops and the ring holds PRE_BEATS fresh beats
  always_ff @(posedge axis_aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      armed      <= 1'b0;
      refill_cnt <= '0;
    end
    else if (fire)
    begin
      armed      <= 1'b0;
      refill_cnt <= '0;
    end
    else if (!armed && !busy && !trig_fire && s_axis_tvalid)
    begin
      if (refill_cnt == PTR_W'(PRE_BEATS - 1))
        armed <= 1'b1;
      refill_cnt <= refill_cnt + 1'b1;
    end
  end

  always_ff @(posedge axis_aclk or negedge rst_n)
  begin
    if (!rst_n)
      trig_fire <= 1'b0;
    else
      trig_fire <= fire;
  end

  always_ff @(posedge axis_aclk)
  begin
    if (fire)
    begin
      trig_evt.stamp    <= beat_cnt;
      trig_evt.lane     <= first_lane;
      trig_evt.beat_ptr <= wr_ptr;
    end
  end

endmodule

// File: hdl/pretrigger_ring_buffer.sv
`timescale 1ns/1ns

module pretrigger_ring_buffer
  import acq_cfg_pkg::*, acq_types_pkg::*;
(
  input  logic             axis_aclk,
  input  logic             rst_n,
  input  adc_word_u        s_axis_tdata,
  input  logic             s_axis_tvalid,
  input  logic             trig_fire,
  input  trig_event_s      trig_evt,
  input  logic             rd_req,
  output logic [PTR_W-1:0] wr_ptr,
  output logic             busy,
  output logic             frame_ready,
  output logic [OUT_W-1:0] rd_word,
  output logic             rd_last
);

  // each slot split into output-sized halves, lower half at index 0
  logic [WORDS_PER_BEAT-1:0][OUT_W-1:0] mem [RING_DEPTH];

  logic              we;
  logic              capturing;
  logic              capt_now;
  logic [PTR_W-1:0]  post_cnt;
  logic [PTR_W-1:0]  post_base;
  logic              frame_done;
  logic [PTR_W-1:0]  rd_slot;
  logic [HALF_W-1:0] rd_half;
  logic [WCNT_W-1:0] rd_cnt;
  logic              final_rd;

  // ring is frozen while a complete frame waits or drains
  assign we = s_axis_tvalid && !frame_ready;

  // trig_fire cycle already counts as post-trigger time
  assign capt_now   = trig_fire || capturing;
  assign post_base  = trig_fire ? '0 : post_cnt;
  assign frame_done = capt_now && s_axis_tvalid &&
                      (post_base == PTR_W'(POST_BEATS - 1));

  assign final_rd = rd_req && (rd_cnt == WCNT_W'(FRAME_WORDS - 1));

  always_ff @(posedge axis_aclk or negedge rst_n)
  begin
    if (!rst_n)
      wr_ptr <= '0;
    else if (we)
      wr_ptr <= wr_ptr + 1'b1;
  end

  always_ff @(posedge axis_aclk)
  begin
    if (we)
      mem[wr_ptr] <= s_axis_tdata.raw;
  end

  // post-trigger beat count
  always_ff @(posedge axis_aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      capturing <= 1'b0;
      post_cnt  <= '0;
    end
    else if (frame_done)
    begin
      capturing <= 1'b0;
    end
    else if (capt_now)
    begin
      capturing <= 1'b1;
      if (s_axis_tvalid)
        post_cnt <= post_base + 1'b1;
      else
        post_cnt <= post_base;
    end
  end

  // busy spans trigger to last read, frame_ready spans freeze to last read
  always_ff @(posedge axis_aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy        <= 1'b0;
      frame_ready <= 1'b0;
    end
    else
    begin
      if (trig_fire)
        busy <= 1'b1;
      else if (final_rd)
        busy <= 1'b0;

      if (frame_done)
        frame_ready <= 1'b1;
      else if (final_rd)
        frame_ready <= 1'b0;
    end
  end

  // read side starts PRE_BEATS slots before the trigger beat
  always_ff @(posedge axis_aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_slot <= '0;
      rd_half <= '0;
      rd_cnt  <= '0;
      rd_last <= 1'b0;
    end
    else if (trig_fire)
    begin
      rd_slot <= trig_evt.beat_ptr - PTR_W'(PRE_BEATS);
      rd_half <= '0;
      rd_cnt  <= '0;
    end
    else if (rd_req)
    begin
      rd_last <= final_rd;
      rd_cnt  <= rd_cnt + 1'b1;
      if (rd_half == HALF_W'(WORDS_PER_BEAT - 1))
      begin
        rd_half <= '0;
        rd_slot <= rd_slot + 1'b1;
      end
      else
      begin
        rd_half <= rd_half + 1'b1;
      end
    end
  end

  // holds its value between requests
  always_ff @(posedge axis_aclk)
  begin
    if (rd_req)
      rd_word <= mem[rd_slot][rd_half];
  end

endmodule

// File: hdl/acq_stream_packetizer.sv
`timescale 1ns/1ns

module acq_stream_packetizer
  import acq_cfg_pkg::*, acq_types_pkg::*;
(
  input  logic             axis_aclk,
  input  logic             rst_n,
  input  logic             frame_ready,
  input  trig_event_s      trig_evt,
  input  logic [OUT_W-1:0] rd_word,
  input  logic             rd_last,
  output logic             rd_req,
  output axis_beat_s       m_axis,
  output logic             m_axis_tvalid,
  input  logic             m_axis_tready
);

  logic       sending;
  logic       pf_valid;
  logic       start;
  logic       out_free;
  logic       load_out;
  axis_beat_s header;

  assign start    = !sending && frame_ready;
  assign out_free = !m_axis_tvalid || m_axis_tready;

  // rd_word acts as the prefetched word, moved out when the output frees
  assign load_out = sending && pf_valid && out_free;

  // first read goes out with the header, later ones refill the prefetch
  assign rd_req = start || (load_out && !rd_last);

  always_comb
  begin
    header = '0;
    header.data[STAMP_W-1:0]          = trig_evt.stamp;
    header.data[STAMP_W +: LANE_IDX_W] = trig_evt.lane;
    header.user = 1'b1;
  end

  always_ff @(posedge axis_aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sending       <= 1'b0;
      m_axis_tvalid <= 1'b0;
      pf_valid      <= 1'b0;
    end
    else
    begin
      if (start)
      begin
        sending       <= 1'b1;
        m_axis_tvalid <= 1'b1;
      end
      else if (load_out)
      begin
        m_axis_tvalid <= 1'b1;
      end
      else if (m_axis_tvalid && m_axis_tready)
      begin
        m_axis_tvalid <= 1'b0;
        // packet ends when the tlast beat is taken
        if (m_axis.last)
          sending <= 1'b0;
      end

      if (rd_req)
        pf_valid <= 1'b1;
      else if (load_out)
        pf_valid <= 1'b0;
    end
  end

  // output beat only changes when empty or accepted
  always_ff @(posedge axis_aclk)
  begin
    if (start)
    begin
      m_axis <= header;
    end
    else if (load_out)
    begin
      m_axis.data <= rd_word;
      m_axis.user <= 1'b0;
      m_axis.last <= rd_last;
    end
  end

endmodule

// File: hdl/acq_top.sv
`timescale 1ns/1ns

module acq_top
  import acq_cfg_pkg::*, acq_types_pkg::*;
(
  input  logic       axis_aclk,
  input  logic       rst_n,
  input  adc_word_u  s_axis_tdata,
  input  logic       s_axis_tvalid,
  output axis_beat_s m_axis,
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready
);

  logic             trig_fire;
  trig_event_s      trig_evt;
  logic             busy;
  logic [PTR_W-1:0] wr_ptr;
  logic             frame_ready;
  logic             rd_req;
  logic [OUT_W-1:0] rd_word;
  logic             rd_last;

  level_trigger trig_i (
    .axis_aclk     (axis_aclk),
    .rst_n         (rst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .busy          (busy),
    .wr_ptr        (wr_ptr),
    .trig_fire     (trig_fire),
    .trig_evt      (trig_evt)
  );

  pretrigger_ring_buffer ring_i (
    .axis_aclk     (axis_aclk),
    .rst_n         (rst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .trig_fire     (trig_fire),
    .trig_evt      (trig_evt),
    .rd_req        (rd_req),
    .wr_ptr        (wr_ptr),
    .busy          (busy),
    .frame_ready   (frame_ready),
    .rd_word       (rd_word),
    .rd_last       (rd_last)
  );

  acq_stream_packetizer pkt_i (
    .axis_aclk     (axis_aclk),
    .rst_n         (rst_n),
    .frame_ready   (frame_ready),
    .trig_evt      (trig_evt),
    .rd_word       (rd_word),
    .rd_last       (rd_last),
    .rd_req        (rd_req),
    .m_axis        (m_axis),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

endmodule

// File: dv/acq_tb_clk.sv
`timescale 1ns/1ns

module acq_tb_clk
(
  output logic clk
);

  localparam int HALF_PERIOD = 5;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

// File: dv/acq_tb.sv
`timescale 1ns/1ns

module acq_tb
  import acq_cfg_pkg::*, acq_types_pkg::*;
;

  localparam int PKT_WORDS   = FRAME_WORDS + 1;
  localparam int PKT_TIMEOUT = 400;
  localparam int DRAIN_CYC   = 4;

  logic       clk;
  logic       rst_n;
  adc_word_u  s_axis_tdata;
  logic       s_axis_tvalid;
  axis_beat_s m_axis;
  logic       m_axis_tvalid;
  logic       m_axis_tready = 1'b1;

  logic [IN_W-1:0] hist [$];
  axis_beat_s      rx_q [$];
  int              beat_idx;
  int              errors;
  int              checks;
  int              tests;
  logic            bp_mode;
  logic            gap_mode;
  logic [31:0]     rdy_state = 32'd63;
  logic [31:0]     gap_state = 32'd63;

  acq_tb_clk clk_i (.clk(clk));

  acq_top dut_i (
    .axis_aclk     (clk),
    .rst_n         (rst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .m_axis        (m_axis),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // lane samples stay below 400, top nibble tags the beat
  function automatic logic [IN_W-1:0] quiet_beat(input int idx);
    adc_word_u w;
    for (int i = 0; i < LANES; i++)
      w.lane[i] = {idx[3:0], 12'((idx * 7 + i * 13) % 400)};
    return w.raw;
  endfunction

  // chosen lane and lane 7 cross, so the lowest one must be reported
  function automatic logic [IN_W-1:0] hit_beat(input int idx, input int lane);
    adc_word_u w;
    w.raw = quiet_beat(idx);
    w.lane[lane][SAMPLE_W-1:0] = 12'(THRESHOLD_LEVEL + idx % 50);
    w.lane[LANES-1][SAMPLE_W-1:0] = 12'd4000;
    return w.raw;
  endfunction

  function automatic logic [IN_W-1:0] high_beat(input int idx);
    adc_word_u w;
    for (int i = 0; i < LANES; i++)
      w.lane[i] = {idx[3:0], 12'd2000};
    return w.raw;
  endfunction

  // word 0 is the header, then two halves per beat starting PRE_BEATS early
  function automatic axis_beat_s expected_word(input int stamp, input int lane, input int k);
    axis_beat_s      w;
    logic [IN_W-1:0] b;
    w = '0;
    if (k == 0)
    begin
      w.data[STAMP_W-1:0] = STAMP_W'(stamp);
      w.data[STAMP_W +: LANE_IDX_W] = LANE_IDX_W'(lane);
      w.user = 1'b1;
    end
    else
    begin
      b = hist[stamp - PRE_BEATS + (k - 1) / WORDS_PER_BEAT];
      w.data = b[((k - 1) % WORDS_PER_BEAT) * OUT_W +: OUT_W];
      w.last = (k == FRAME_WORDS);
    end
    return w;
  endfunction

  task automatic check(input string name, input logic [65:0] exp, input logic [65:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic send_beat(input logic [IN_W-1:0] data);
    int gap;
    gap = 0;
    if (gap_mode)
    begin
      gap_state = xorshift(gap_state);
      gap = gap_state % 3;
    end
    repeat (gap)
    begin
      @(posedge clk);
      s_axis_tvalid <= 1'b0;
    end
    @(posedge clk);
    s_axis_tdata  <= data;
    s_axis_tvalid <= 1'b1;
    hist.push_back(data);
    beat_idx++;
  endtask

  task automatic send_quiet(input int n);
    repeat (n)
      send_beat(quiet_beat(beat_idx));
  endtask

  task automatic send_trigger(input int lane, output int stamp);
    stamp = beat_idx;
    send_beat(hit_beat(beat_idx, lane));
  endtask

  task automatic expect_packet(input string name, input int stamp, input int lane);
    int cyc;
    cyc = 0;
    while (rx_q.size() < PKT_WORDS && cyc < PKT_TIMEOUT)
    begin
      @(posedge clk);
      s_axis_tvalid <= 1'b0;
      cyc++;
    end
    if (rx_q.size() < PKT_WORDS)
    begin
      errors++;
      $display("%s: no complete packet within %0d cycles, only %0d of %0d beats came out",
               name, PKT_TIMEOUT, rx_q.size(), PKT_WORDS);
    end
    else
    begin
      // a repeated word would show up right behind tlast
      repeat (DRAIN_CYC)
      begin
        @(posedge clk);
        s_axis_tvalid <= 1'b0;
      end
      check({name, " beats out"}, 66'(PKT_WORDS), 66'(rx_q.size()));
      for (int k = 0; k < PKT_WORDS; k++)
        check($sformatf("%s word %0d", name, k), expected_word(stamp, lane, k), rx_q[k]);
    end
    rx_q.delete();
  endtask

  task automatic expect_silence(input string name, input int n);
    repeat (n)
    begin
      @(posedge clk);
      s_axis_tvalid <= 1'b0;
    end
    check({name, " beats out"}, 66'd0, 66'(rx_q.size()));
    rx_q.delete();
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before)
      $display("%s: ok", name);
    else
      $display("%s: FAILED with %0d errors", name, errors - err_before);
  endtask

  task automatic test_idle();
    int e;
    e = errors;
    send_quiet(60);
    expect_silence("test_idle", 40);
    report_test("test_idle", e);
  endtask

  task automatic test_single_capture();
    int e;
    int stamp;
    e = errors;
    send_quiet(6);
    send_trigger(3, stamp);
    send_quiet(POST_BEATS);
    expect_packet("test_single_capture", stamp, 3);
    report_test("test_single_capture", e);
  endtask

  task automatic test_backpressure();
    int e;
    int stamp;
    e = errors;
    bp_mode = 1'b1;
    send_quiet(6);
    send_trigger(0, stamp);
    send_quiet(POST_BEATS);
    expect_packet("test_backpressure", stamp, 0);
    bp_mode = 1'b0;
    report_test("test_backpressure", e);
  endtask

  task automatic test_input_gaps();
    int e;
    int stamp;
    e = errors;
    gap_mode = 1'b1;
    send_quiet(6);
    send_trigger(5, stamp);
    send_quiet(POST_BEATS);
    expect_packet("test_input_gaps", stamp, 5);
    gap_mode = 1'b0;
    report_test("test_input_gaps", e);
  endtask

  task automatic test_rearm();
    int e;
    int stamp;
    e = errors;
    send_quiet(6);
    send_trigger(6, stamp);
    // crossing inside the post-trigger window
    send_quiet(3);
    send_beat(hit_beat(beat_idx, 1));
    send_quiet(POST_BEATS - 4);
    // crossing while the frame is frozen, dropped from the ring
    send_quiet(1);
    send_beat(hit_beat(beat_idx, 1));
    send_quiet(2);
    expect_packet("test_rearm busy", stamp, 6);
    // crossing before the ring is refilled, then a held level
    send_quiet(1);
    send_beat(hit_beat(beat_idx, 2));
    repeat (8)
      send_beat(high_beat(beat_idx));
    // enough beats for a wrongly started frame to complete
    send_quiet(POST_BEATS);
    expect_silence("test_rearm blocked", 40);
    send_quiet(1);
    send_trigger(2, stamp);
    send_quiet(POST_BEATS);
    expect_packet("test_rearm clean", stamp, 2);
    report_test("test_rearm", e);
  endtask

  // random ready only in the backpressure test
  always @(posedge clk)
  begin
    if (bp_mode)
    begin
      rdy_state = xorshift(rdy_state);
      m_axis_tready <= rdy_state[0];
    end
    else
    begin
      m_axis_tready <= 1'b1;
    end
  end

  always @(posedge clk)
  begin
    if (rst_n && m_axis_tvalid && m_axis_tready)
      rx_q.push_back(m_axis);
  end

  initial
  begin
    rst_n         = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    bp_mode       = 1'b0;
    gap_mode      = 1'b0;
    beat_idx      = 0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_idle();
    test_single_capture();
    test_backpressure();
    test_input_gaps();
    test_rearm();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: verilog.f
hdl/acq_cfg_pkg.sv
hdl/acq_types_pkg.sv
hdl/level_trigger.sv
hdl/pretrigger_ring_buffer.sv
hdl/acq_stream_packetizer.sv
hdl/acq_top.sv
dv/acq_tb_clk.sv
dv/acq_tb.sv
